// File: hdl/recovery_pkg.sv
// Recovery executor package with bus widths, command codes, register indices and status codes
`default_nettype none

package recovery_pkg;

  // One RX queue word and one register word
  typedef logic [31:0] word_t;

  // One response byte
  typedef logic [7:0] byte_t;

  // Byte length of a command or a response
  typedef logic [15:0] len_t;

  localparam int unsigned WORD_BYTES = 4;

  // Recovery command codes handled by the executor
  typedef enum logic [7:0] {
    CMD_PROT_CAP        = 8'd34,
    CMD_DEVICE_STATUS   = 8'd36,
    CMD_DEVICE_RESET    = 8'd37,
    CMD_RECOVERY_CTRL   = 8'd38,
    CMD_RECOVERY_STATUS = 8'd39
  } cmd_e;

  // Word index into the recovery register space
  typedef enum logic [3:0] {
    IDX_PROT_CAP_0      = 4'd0,
    IDX_PROT_CAP_1      = 4'd1,
    IDX_PROT_CAP_2      = 4'd2,
    IDX_PROT_CAP_3      = 4'd3,
    IDX_DEVICE_STATUS_0 = 4'd4,
    IDX_DEVICE_STATUS_1 = 4'd5,
    IDX_DEVICE_RESET    = 4'd6,
    IDX_RECOVERY_CTRL   = 4'd7,
    IDX_RECOVERY_STATUS = 4'd8,
    IDX_INVALID         = 4'd15
  } reg_idx_e;

  // Protocol status reported in DEVICE_STATUS byte 1
  typedef enum logic [7:0] {
    PROTO_OK            = 8'h00,
    PROTO_ERR_READ_ONLY = 8'h01,
    PROTO_ERR_PARAMETER = 8'h02,
    PROTO_ERR_LENGTH    = 8'h03,
    PROTO_ERR_CRC       = 8'h04
  } proto_status_e;

endpackage

`default_nettype wire

// File: hdl/recovery_reg_map.sv
// Recovery register map that turns a command into its word index and byte length
`timescale 1ns/10ps
`default_nettype none

module recovery_reg_map (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   load_i,
  input  recovery_pkg::cmd_e     cmd_i,
  input  logic                   step_i,
  output recovery_pkg::reg_idx_e reg_idx_o,
  output recovery_pkg::len_t     reg_len_o
);
  import recovery_pkg::*;

  reg_idx_e first_idx;
  reg_idx_e last_idx;
  len_t     len_d;
  reg_idx_e idx_q;
  reg_idx_e last_q;
  len_t     len_q;

  always_comb begin
    unique case (cmd_i)
      CMD_PROT_CAP: begin
        first_idx = IDX_PROT_CAP_0;
        last_idx  = IDX_PROT_CAP_3;
        len_d     = 16'd15;
      end
      CMD_DEVICE_STATUS: begin
        first_idx = IDX_DEVICE_STATUS_0;
        last_idx  = IDX_DEVICE_STATUS_1;
        len_d     = 16'd8;
      end
      CMD_DEVICE_RESET: begin
        first_idx = IDX_DEVICE_RESET;
        last_idx  = IDX_DEVICE_RESET;
        len_d     = 16'd3;
      end
      CMD_RECOVERY_CTRL: begin
        first_idx = IDX_RECOVERY_CTRL;
        last_idx  = IDX_RECOVERY_CTRL;
        len_d     = 16'd3;
      end
      CMD_RECOVERY_STATUS: begin
        first_idx = IDX_RECOVERY_STATUS;
        last_idx  = IDX_RECOVERY_STATUS;
        len_d     = 16'd2;
      end
      // Unknown code reads back as one zero word
      default: begin
        first_idx = IDX_INVALID;
        last_idx  = IDX_INVALID;
        len_d     = len_t'(WORD_BYTES);
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q  <= IDX_INVALID;
      last_q <= IDX_INVALID;
      len_q  <= '0;
    end else if (load_i) begin
      idx_q  <= first_idx;
      last_q <= last_idx;
      len_q  <= len_d;
    end else if (step_i) begin
      // Stepping past the last word leaves the register
      idx_q <= (idx_q == last_q) ? IDX_INVALID : reg_idx_e'(idx_q + 4'd1);
    end
  end

  assign reg_idx_o = idx_q;
  assign reg_len_o = len_q;

  a_idx_defined: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (idx_q <= IDX_RECOVERY_STATUS) || (idx_q == IDX_INVALID));

endmodule

`default_nettype wire

// File: hdl/recovery_reg_file.sv
// Recovery register file with writable control registers, device status and the read mux
`timescale 1ns/10ps
`default_nettype none

module recovery_reg_file #(
  parameter logic [127:0] P_PROT_CAP = '0
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  recovery_pkg::reg_idx_e      reg_idx_i,
  input  logic                        wr_en_i,
  input  recovery_pkg::word_t         wr_data_i,
  input  logic                        status_we_i,
  input  recovery_pkg::proto_status_e status_i,
  input  recovery_pkg::word_t         rec_status_i,
  output recovery_pkg::word_t         rd_word_o,
  output logic                        image_activated_o
);
  import recovery_pkg::*;

  word_t         device_reset_q;
  word_t         recovery_ctrl_q;
  proto_status_e proto_status_q;
  word_t         device_status_0;

  // Only DEVICE_RESET and RECOVERY_CTRL accept host writes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      device_reset_q  <= '0;
      recovery_ctrl_q <= '0;
    end else if (wr_en_i) begin
      case (reg_idx_i)
        IDX_DEVICE_RESET:  device_reset_q  <= wr_data_i;
        IDX_RECOVERY_CTRL: recovery_ctrl_q <= wr_data_i;
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      proto_status_q <= PROTO_OK;
    end else if (status_we_i) begin
      proto_status_q <= status_i;
    end
  end

  // Device status and reason bytes stay zero
  assign device_status_0 = {16'h0000, proto_status_q, 8'h00};

  always_comb begin
    unique case (reg_idx_i)
      IDX_PROT_CAP_0:      rd_word_o = P_PROT_CAP[31:0];
      IDX_PROT_CAP_1:      rd_word_o = P_PROT_CAP[63:32];
      IDX_PROT_CAP_2:      rd_word_o = P_PROT_CAP[95:64];
      IDX_PROT_CAP_3:      rd_word_o = P_PROT_CAP[127:96];
      IDX_DEVICE_STATUS_0: rd_word_o = device_status_0;
      IDX_DEVICE_STATUS_1: rd_word_o = '0;
      IDX_DEVICE_RESET:    rd_word_o = device_reset_q;
      IDX_RECOVERY_CTRL:   rd_word_o = recovery_ctrl_q;
      IDX_RECOVERY_STATUS: rd_word_o = rec_status_i;
      default:             rd_word_o = '0;
    endcase
  end

  // Activate image command in RECOVERY_CTRL byte 2
  assign image_activated_o = (recovery_ctrl_q[23:16] == 8'h0F);

  a_wr_vs_status: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wr_en_i && status_we_i));

endmodule

`default_nettype wire

// File: hdl/recovery_cmd_seq.sv
// Recovery command sequencer that runs writes from the RX queue and streams read responses
`timescale 1ns/10ps
`default_nettype none

module recovery_cmd_seq (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  input  logic                        cmd_valid_i,
  input  logic                        cmd_is_rd_i,
  input  recovery_pkg::cmd_e          cmd_cmd_i,
  input  recovery_pkg::len_t          cmd_len_i,
  input  logic                        cmd_error_i,
  output logic                        cmd_done_o,

  output logic                        rx_req_o,
  input  logic                        rx_ack_i,
  output logic                        rx_queue_clr_o,
  input  logic                        host_abort_i,

  output logic                        res_valid_o,
  input  logic                        res_ready_i,
  output recovery_pkg::len_t          res_len_o,
  output logic                        res_dvalid_o,
  input  logic                        res_dready_i,
  output recovery_pkg::byte_t         res_data_o,
  output logic                        res_dlast_o,

  output logic                        load_o,
  output logic                        step_o,
  input  recovery_pkg::len_t          reg_len_i,
  output logic                        wr_en_o,
  output logic                        status_we_o,
  output recovery_pkg::proto_status_e status_o,
  input  recovery_pkg::word_t         rd_word_i
);
  import recovery_pkg::*;

  typedef enum logic [2:0] {
    Idle,
    Write,
    ReadHdr,
    ReadData,
    Error,
    Done
  } state_e;

  state_e        state_q;
  state_e        state_d;
  len_t          cnt_q;
  logic [1:0]    bsel_q;
  proto_status_e status_q;
  len_t          wr_words;
  logic          byte_hs;
  logic          wr_last;

  // Write length rounded up to whole words
  assign wr_words = (cmd_len_i >> 2) + len_t'(|cmd_len_i[1:0]);

  assign byte_hs = res_dvalid_o && res_dready_i;
  assign wr_last = rx_ack_i && (cnt_q == len_t'(1));

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: begin
        if (cmd_valid_i) begin
          if (cmd_error_i) begin
            state_d = Error;
          end else if (cmd_is_rd_i) begin
            state_d = ReadHdr;
          end else begin
            state_d = Write;
          end
        end
      end
      // A zero-length write leaves after one cycle
      Write: begin
        if ((cnt_q == '0) || wr_last) begin
          state_d = Done;
        end
      end
      ReadHdr: begin
        if (res_ready_i) begin
          state_d = ReadData;
        end
      end
      ReadData: begin
        if (host_abort_i) begin
          state_d = Error;
        end else if (byte_hs && res_dlast_o) begin
          state_d = Done;
        end
      end
      Error:   state_d = Done;
      Done:    state_d = Idle;
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Remaining words on a write and remaining bytes on a read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q  <= '0;
      bsel_q <= '0;
    end else begin
      case (state_q)
        Idle: begin
          bsel_q <= '0;
          if (cmd_valid_i) begin
            cnt_q <= wr_words;
          end
        end
        Write: begin
          if (rx_ack_i) begin
            cnt_q <= cnt_q - len_t'(1);
          end
        end
        ReadHdr: begin
          if (res_ready_i) begin
            cnt_q <= reg_len_i;
          end
        end
        ReadData: begin
          if (byte_hs) begin
            cnt_q  <= cnt_q - len_t'(1);
            bsel_q <= bsel_q + 2'd1;
          end
        end
        default: begin
        end
      endcase
    end
  end

  // Queue request drops the cycle after the last ack
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_req_o <= 1'b0;
    end else begin
      case (state_q)
        Idle:    rx_req_o <= cmd_valid_i && !cmd_error_i && !cmd_is_rd_i &&
                             (cmd_len_i != '0);
        Write:   rx_req_o <= (cnt_q != '0) && !wr_last;
        default: rx_req_o <= 1'b0;
      endcase
    end
  end

  // Command status reported when the command completes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      status_q <= PROTO_OK;
    end else if ((state_q == Idle) && cmd_valid_i) begin
      status_q <= cmd_error_i ? PROTO_ERR_CRC : PROTO_OK;
    end
  end

  assign load_o         = (state_q == Idle) && cmd_valid_i;
  assign wr_en_o        = (state_q == Write) && rx_ack_i;
  assign step_o         = wr_en_o || (byte_hs && (bsel_q == 2'(WORD_BYTES - 1)));
  assign cmd_done_o     = (state_q == Done);
  assign rx_queue_clr_o = (state_q == Error);
  assign status_we_o    = (state_q == Done);
  assign status_o       = status_q;

  assign res_valid_o  = (state_q == ReadHdr);
  assign res_len_o    = reg_len_i;
  assign res_dvalid_o = (state_q == ReadData);
  assign res_dlast_o  = res_dvalid_o && (cnt_q == len_t'(1));
  // Little-endian byte order within the word
  assign res_data_o   = rd_word_i[8 * bsel_q +: 8];

  a_cmd_in_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_i |-> (state_q == Idle));

  a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_ack_i |-> rx_req_o);

  a_hdr_before_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(res_dvalid_o && res_valid_o));

endmodule

`default_nettype wire

// File: hdl/recovery_executor.sv
// Recovery command executor top level joining the sequencer, register map and register file
`timescale 1ns/10ps
`default_nettype none

module recovery_executor #(
  parameter logic [127:0] P_PROT_CAP = {32'h000F0011, 32'h00000101, 32'h56434552, 32'h2050434F}
) (
  input  logic                clk_i,
  input  logic                rst_ni,

  input  logic                cmd_valid_i,
  input  logic                cmd_is_rd_i,
  input  recovery_pkg::cmd_e  cmd_cmd_i,
  input  recovery_pkg::len_t  cmd_len_i,
  input  logic                cmd_error_i,
  output logic                cmd_done_o,

  output logic                res_valid_o,
  input  logic                res_ready_i,
  output recovery_pkg::len_t  res_len_o,

  output logic                res_dvalid_o,
  input  logic                res_dready_i,
  output recovery_pkg::byte_t res_data_o,
  output logic                res_dlast_o,

  output logic                rx_req_o,
  input  logic                rx_ack_i,
  input  recovery_pkg::word_t rx_data_i,
  output logic                rx_queue_clr_o,

  input  logic                host_abort_i,
  input  recovery_pkg::word_t rec_status_i,
  output logic                image_activated_o
);
  import recovery_pkg::*;

  logic          load;
  logic          step;
  logic          wr_en;
  logic          status_we;
  proto_status_e status;
  reg_idx_e      reg_idx;
  len_t          reg_len;
  word_t         rd_word;

  recovery_cmd_seq u_seq (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_is_rd_i    (cmd_is_rd_i),
    .cmd_cmd_i      (cmd_cmd_i),
    .cmd_len_i      (cmd_len_i),
    .cmd_error_i    (cmd_error_i),
    .cmd_done_o     (cmd_done_o),
    .rx_req_o       (rx_req_o),
    .rx_ack_i       (rx_ack_i),
    .rx_queue_clr_o (rx_queue_clr_o),
    .host_abort_i   (host_abort_i),
    .res_valid_o    (res_valid_o),
    .res_ready_i    (res_ready_i),
    .res_len_o      (res_len_o),
    .res_dvalid_o   (res_dvalid_o),
    .res_dready_i   (res_dready_i),
    .res_data_o     (res_data_o),
    .res_dlast_o    (res_dlast_o),
    .load_o         (load),
    .step_o         (step),
    .reg_len_i      (reg_len),
    .wr_en_o        (wr_en),
    .status_we_o    (status_we),
    .status_o       (status),
    .rd_word_i      (rd_word)
  );

  recovery_reg_map u_map (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .load_i    (load),
    .cmd_i     (cmd_cmd_i),
    .step_i    (step),
    .reg_idx_o (reg_idx),
    .reg_len_o (reg_len)
  );

  recovery_reg_file #(
    .P_PROT_CAP (P_PROT_CAP)
  ) u_regs (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .reg_idx_i         (reg_idx),
    .wr_en_i           (wr_en),
    .wr_data_i         (rx_data_i),
    .status_we_i       (status_we),
    .status_i          (status),
    .rec_status_i      (rec_status_i),
    .rd_word_o         (rd_word),
    .image_activated_o (image_activated_o)
  );

endmodule

`default_nettype wire

// File: tests/tb_recovery_executor.sv
// Testbench for the recovery command executor with a register model and assertion checks
`timescale 1ns/10ps
`default_nettype none

module tb_recovery_executor;
  import recovery_pkg::*;

  // Increasing byte values expose any byte ordering mistake
  localparam logic [127:0] PROT_CAP = 128'hA50E0D0C_0B0A0908_07060504_03020100;

  logic          clk_i = 1'b0;
  logic          rst_ni;
  logic          cmd_valid_i;
  logic          cmd_is_rd_i;
  cmd_e          cmd_cmd_i;
  len_t          cmd_len_i;
  logic          cmd_error_i;
  logic          cmd_done_o;
  logic          res_valid_o;
  logic          res_ready_i;
  len_t          res_len_o;
  logic          res_dvalid_o;
  logic          res_dready_i;
  byte_t         res_data_o;
  logic          res_dlast_o;
  logic          rx_req_o;
  logic          rx_ack_i;
  word_t         rx_data_i;
  logic          rx_queue_clr_o;
  logic          host_abort_i;
  word_t         rec_status_i;
  logic          image_activated_o;

  // Register model and expected response
  word_t         seed = 32'ha067ffff;
  word_t         model_reset = '0;
  word_t         model_ctrl = '0;
  proto_status_e exp_proto = PROTO_OK;
  byte_t         exp_bytes [16];
  len_t          exp_len = '0;
  byte_t         exp_byte;
  logic          exp_last;
  logic          exp_img = 1'b0;
  int            exp_words = 0;
  logic          rd_active = 1'b0;
  logic          wr_active = 1'b0;

  // Observed progress of the current command
  logic          aborted = 1'b0;
  logic          hdr_seen = 1'b0;
  int            byte_idx = 0;
  int            ack_cnt = 0;
  int            cycle_cnt = 0;
  int            cmd_cnt = 0;
  int            err_cnt = 0;
  int            err_mark = 0;
  int            tests_run = 0;
  int            tests_failed = 0;
  string         test_name = "reset";

  recovery_executor #(
    .P_PROT_CAP (PROT_CAP)
  ) u_dut (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .cmd_valid_i       (cmd_valid_i),
    .cmd_is_rd_i       (cmd_is_rd_i),
    .cmd_cmd_i         (cmd_cmd_i),
    .cmd_len_i         (cmd_len_i),
    .cmd_error_i       (cmd_error_i),
    .cmd_done_o        (cmd_done_o),
    .res_valid_o       (res_valid_o),
    .res_ready_i       (res_ready_i),
    .res_len_o         (res_len_o),
    .res_dvalid_o      (res_dvalid_o),
    .res_dready_i      (res_dready_i),
    .res_data_o        (res_data_o),
    .res_dlast_o       (res_dlast_o),
    .rx_req_o          (rx_req_o),
    .rx_ack_i          (rx_ack_i),
    .rx_data_i         (rx_data_i),
    .rx_queue_clr_o    (rx_queue_clr_o),
    .host_abort_i      (host_abort_i),
    .rec_status_i      (rec_status_i),
    .image_activated_o (image_activated_o)
  );

  always #10 clk_i = ~clk_i;

  function automatic word_t next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Low LCG bits repeat quickly so only the upper ones are used
  function automatic int rand_below(input int n);
    return int'(next_rand() >> 8) % n;
  endfunction

  // Register contents as the host sees them with byte 0 first
  function automatic logic [127:0] reg_contents(input cmd_e cmd);
    case (cmd)
      CMD_PROT_CAP:        return PROT_CAP;
      CMD_DEVICE_STATUS:   return {112'h0, exp_proto, 8'h00};
      CMD_DEVICE_RESET:    return {96'h0, model_reset};
      CMD_RECOVERY_CTRL:   return {96'h0, model_ctrl};
      CMD_RECOVERY_STATUS: return {96'h0, rec_status_i};
      default:             return '0;
    endcase
  endfunction

  function automatic len_t reg_length(input cmd_e cmd);
    case (cmd)
      CMD_PROT_CAP:        return 16'd15;
      CMD_DEVICE_STATUS:   return 16'd8;
      CMD_DEVICE_RESET:    return 16'd3;
      CMD_RECOVERY_CTRL:   return 16'd3;
      CMD_RECOVERY_STATUS: return 16'd2;
      default:             return 16'd4;
    endcase
  endfunction

  assign exp_byte = exp_bytes[byte_idx[3:0]];
  assign exp_last = (byte_idx == int'(exp_len) - 1);

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cmd_valid_i) begin
      byte_idx <= 0;
      ack_cnt  <= 0;
      aborted  <= 1'b0;
      hdr_seen <= 1'b0;
    end else begin
      if (res_valid_o && res_ready_i) begin
        hdr_seen <= 1'b1;
      end
      if (res_dvalid_o && res_dready_i) begin
        byte_idx <= byte_idx + 1;
      end
      if (rx_ack_i) begin
        ack_cnt <= ack_cnt + 1;
      end
      if (host_abort_i) begin
        aborted <= 1'b1;
      end
    end
  end

  // Each command gets 64 cycles on top of a fixed margin
  always @(posedge clk_i) begin
    if (cycle_cnt > 100 + 64 * cmd_cnt) begin
      $display("Timeout after %0d cycles with %0d commands issued", cycle_cnt, cmd_cnt);
      $display("Test failed");
      $finish;
    end
  end

  a_hdr_len: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_o && res_ready_i |-> res_len_o == exp_len)
    else begin
      $display("Fail %s: length expected %0d actual %0d", test_name,
               $sampled(exp_len), $sampled(res_len_o));
      err_cnt++;
    end

  a_hdr_first: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_dvalid_o |-> hdr_seen)
    else begin
      $display("Response bytes started before the header handshake in %s", test_name);
      err_cnt++;
    end

  a_byte: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_dvalid_o && res_dready_i |-> res_data_o == exp_byte && res_dlast_o == exp_last)
    else begin
      $display("Fail %s: byte %0d expected %h last %b actual %h last %b", test_name,
               $sampled(byte_idx), $sampled(exp_byte), $sampled(exp_last),
               $sampled(res_data_o), $sampled(res_dlast_o));
      err_cnt++;
    end

  a_done_after_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_dvalid_o && res_dready_i && res_dlast_o |=> cmd_done_o)
    else begin
      $display("Command did not finish after the last byte in %s", test_name);
      err_cnt++;
    end

  a_rd_count: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_done_o && rd_active && !aborted |-> byte_idx == int'(exp_len))
    else begin
      $display("Fail %s: bytes expected %0d actual %0d", test_name,
               $sampled(exp_len), $sampled(byte_idx));
      err_cnt++;
    end

  a_wr_count: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_done_o && wr_active |-> ack_cnt == exp_words)
    else begin
      $display("Fail %s: words expected %0d actual %0d", test_name,
               $sampled(exp_words), $sampled(ack_cnt));
      err_cnt++;
    end

  a_req_drop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_ack_i && (ack_cnt + 1 == exp_words) |=> !rx_req_o)
    else begin
      $display("RX request stayed high after the last word in %s", test_name);
      err_cnt++;
    end

  a_image: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_done_o |-> image_activated_o == exp_img)
    else begin
      $display("Fail %s: image activated expected %b actual %b", test_name,
               $sampled(exp_img), $sampled(image_activated_o));
      err_cnt++;
    end

  a_queue_clr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cmd_valid_i && cmd_error_i) || (host_abort_i && res_dvalid_o) |=> rx_queue_clr_o)
    else begin
      $display("RX queue was not cleared after an error or abort in %s", test_name);
      err_cnt++;
    end

  a_clr_then_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_queue_clr_o |=> cmd_done_o)
    else begin
      $display("Command did not finish after the queue clear in %s", test_name);
      err_cnt++;
    end

  a_no_byte_after_abort: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aborted |-> !(res_dvalid_o && res_dready_i))
    else begin
      $display("A byte was accepted after the host abort in %s", test_name);
      err_cnt++;
    end

  task automatic issue_cmd(input logic is_rd, input cmd_e cmd, input len_t len,
                           input logic err);
    @(posedge clk_i);
    cmd_valid_i <= 1'b1;
    cmd_is_rd_i <= is_rd;
    cmd_cmd_i   <= cmd;
    cmd_len_i   <= len;
    cmd_error_i <= err;
    rd_active   <= is_rd && !err;
    wr_active   <= !is_rd && !err;
    cmd_cnt     <= cmd_cnt + 1;
    @(posedge clk_i);
    cmd_valid_i <= 1'b0;
    cmd_error_i <= 1'b0;
  endtask

  task automatic wait_done(input logic err);
    do begin
      @(posedge clk_i);
    end while (!cmd_done_o);
    exp_proto = err ? PROTO_ERR_CRC : PROTO_OK;
  endtask

  // Host write fed from the RX queue with random gaps between acks
  task automatic write_register(input cmd_e cmd, input len_t len, input logic err,
                                input word_t first_word, input int gap_max);
    int words;
    int sent;
    int gap;
    words = err ? 0 : (int'(len) + 3) / 4;
    if (words > 0 && cmd == CMD_DEVICE_RESET) begin
      model_reset = first_word;
    end
    if (words > 0 && cmd == CMD_RECOVERY_CTRL) begin
      model_ctrl = first_word;
    end
    exp_img   <= (model_ctrl[23:16] == 8'h0F);
    exp_words <= words;
    issue_cmd(1'b0, cmd, len, err);
    sent = 0;
    gap  = rand_below(gap_max + 1);
    while (sent < words) begin
      @(posedge clk_i);
      rx_ack_i <= 1'b0;
      if (rx_req_o && gap > 0) begin
        gap = gap - 1;
      end else if (rx_req_o) begin
        rx_ack_i  <= 1'b1;
        rx_data_i <= (sent == 0) ? first_word : next_rand();
        sent = sent + 1;
        gap  = rand_below(gap_max + 1);
      end
    end
    @(posedge clk_i);
    rx_ack_i <= 1'b0;
    wait_done(err);
  endtask

  // Host read with optional stalls and an abort once abort_at bytes are through
  task automatic read_register(input cmd_e cmd, input logic stall, input int abort_at);
    int           got;
    logic         abort_sent;
    word_t        r;
    logic [127:0] src;
    src = reg_contents(cmd);
    for (int k = 0; k < 16; k++) begin
      exp_bytes[k] <= src[8 * k +: 8];
    end
    exp_len <= reg_length(cmd);
    issue_cmd(1'b1, cmd, '0, 1'b0);
    got        = 0;
    abort_sent = 1'b0;
    do begin
      @(posedge clk_i);
      if (res_dvalid_o && res_dready_i) begin
        got = got + 1;
      end
      host_abort_i <= 1'b0;
      if (!abort_sent && res_dvalid_o && got == abort_at) begin
        host_abort_i <= 1'b1;
        abort_sent = 1'b1;
      end
      r = next_rand();
      res_ready_i  <= !stall || (r[31:30] != 2'b00);
      res_dready_i <= !stall || (r[29:28] != 2'b00);
    end while (!cmd_done_o);
    res_ready_i  <= 1'b1;
    res_dready_i <= 1'b1;
    exp_proto = PROTO_OK;
  endtask

  task automatic open_test(input string name);
    test_name = name;
    err_mark  = err_cnt;
  endtask

  task automatic close_test();
    tests_run++;
    if (err_cnt != err_mark) begin
      tests_failed++;
    end
    $display("%s finished with %0d errors", test_name, err_cnt - err_mark);
  endtask

  initial begin
    word_t w;
    rst_ni       <= 1'b0;
    cmd_valid_i  <= 1'b0;
    cmd_is_rd_i  <= 1'b0;
    cmd_cmd_i    <= CMD_PROT_CAP;
    cmd_len_i    <= '0;
    cmd_error_i  <= 1'b0;
    res_ready_i  <= 1'b1;
    res_dready_i <= 1'b1;
    rx_ack_i     <= 1'b0;
    rx_data_i    <= '0;
    host_abort_i <= 1'b0;
    rec_status_i <= '0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    open_test("prot_cap_read");
    read_register(CMD_PROT_CAP, 1'b0, -1);
    close_test();

    open_test("recovery_ctrl");
    w = next_rand();
    w[23:16] = 8'h0F;
    write_register(CMD_RECOVERY_CTRL, 16'd3, 1'b0, w, 0);
    read_register(CMD_RECOVERY_CTRL, 1'b0, -1);
    w = next_rand();
    if (w[23:16] == 8'h0F) begin
      w[16] = 1'b0;
    end
    write_register(CMD_RECOVERY_CTRL, 16'd3, 1'b0, w, 2);
    read_register(CMD_RECOVERY_CTRL, 1'b0, -1);
    close_test();

    open_test("read_only_and_unknown");
    rec_status_i <= next_rand();
    write_register(CMD_RECOVERY_STATUS, 16'd2, 1'b0, next_rand(), 2);
    read_register(CMD_RECOVERY_STATUS, 1'b0, -1);
    read_register(cmd_e'(8'd50), 1'b0, -1);
    close_test();

    open_test("crc_error");
    write_register(CMD_DEVICE_RESET, 16'd4, 1'b1, next_rand(), 0);
    read_register(CMD_DEVICE_STATUS, 1'b0, -1);
    read_register(CMD_DEVICE_STATUS, 1'b0, -1);
    close_test();

    open_test("reset_overlong_write");
    write_register(CMD_DEVICE_RESET, 16'd8, 1'b0, next_rand(), 5);
    read_register(CMD_DEVICE_RESET, 1'b0, -1);
    close_test();

    open_test("abort_read");
    read_register(CMD_PROT_CAP, 1'b1, 1 + rand_below(10));
    read_register(CMD_PROT_CAP, 1'b1, -1);
    close_test();

    $display("Tests run: %0d, tests failed: %0d, check errors: %0d",
             tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: recovery_executor.f
hdl/recovery_pkg.sv
hdl/recovery_reg_map.sv
hdl/recovery_reg_file.sv
hdl/recovery_cmd_seq.sv
hdl/recovery_executor.sv
tests/tb_recovery_executor.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       ?= tb_recovery_executor
FILELIST  ?= recovery_executor.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Test completed successfully

.PHONY: sim clean

# Output goes to the terminal, grep decides the exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
